/* hw/noc_pkg.sv */
// ------------------------------------------------------------------------
// Mesh router shared definitions
// Packet layout, port numbering and the vector types used between the
// queues, route decoders, switch allocator and output stage
// ------------------------------------------------------------------------

package noc_pkg;

  // Router ports
  // ------------------------------------------------------------------------
  localparam int unsigned NUM_PORTS = 5;       // Core plus four mesh neighbors

  localparam int unsigned PORT_CORE  = 0;      // Local processing element
  localparam int unsigned PORT_NORTH = 1;      // Toward smaller y
  localparam int unsigned PORT_EAST  = 2;      // Toward larger x
  localparam int unsigned PORT_SOUTH = 3;      // Toward larger y
  localparam int unsigned PORT_WEST  = 4;      // Toward smaller x

  // Packet fields
  // ------------------------------------------------------------------------
  localparam int unsigned COORD_W   = 3;       // Up to 8 by 8 mesh
  localparam int unsigned PAYLOAD_W = 16;

  // Dest x on top, dest y below it, payload in the low bits
  localparam int unsigned PACKET_W  = 2 * COORD_W + PAYLOAD_W;

  typedef logic [COORD_W-1:0]   coord_t;       // One mesh coordinate
  typedef logic [PAYLOAD_W-1:0] payload_t;     // Packet payload
  typedef logic [PACKET_W-1:0]  packet_t;      // {dest_x, dest_y, payload}

  // One bit per port, indexed by the PORT_* constants
  typedef logic [NUM_PORTS-1:0] port_mask_t;

endpackage

/* hw/input_queue.sv */
// ------------------------------------------------------------------------
// Input queue
// Circular packet buffer for one router input port; accepts on valid and
// enable, shows its oldest packet at the head, pops on a grant
// ------------------------------------------------------------------------

module input_queue #(
  parameter int unsigned QUEUE_DEPTH = 4     // Packets held per port
) (
  input  logic             clk,
  input  logic             reset_n,
  input  noc_pkg::packet_t i_data,           // From upstream neighbor
  input  logic             i_data_val,       // Upstream packet valid
  input  logic             i_pop,            // Grant from allocator
  output noc_pkg::packet_t o_head,           // Oldest packet
  output logic             o_head_val,       // Head holds a packet
  output logic             o_en              // To upstream, high while not full
);
  import noc_pkg::*;

  localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;           // Slot index
  typedef logic [CNT_W-1:0] cnt_t;           // Occupancy, 0 to QUEUE_DEPTH

  packet_t mem [QUEUE_DEPTH];                // Packet storage
  ptr_t    wr_ptr;                           // Next free slot
  ptr_t    rd_ptr;                           // Head slot
  cnt_t    count;                            // Packets stored
  logic    push;

  // Wraps at QUEUE_DEPTH, so depths that are not a power of two work too
  function automatic ptr_t ptr_inc(ptr_t ptr);
    if (ptr == ptr_t'(QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push       = i_data_val && o_en;    // Upstream handshake
  assign o_en       = (count != cnt_t'(QUEUE_DEPTH));
  assign o_head_val = (count != '0);
  assign o_head     = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;                 // Storage needs no reset
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_inc(wr_ptr);
      if (i_pop) rd_ptr <= ptr_inc(rd_ptr);
      case ({push, i_pop})
        2'b10:   count <= count + 1'b1;      // Write only
        2'b01:   count <= count - 1'b1;      // Pop only
        default: ;                           // Both or neither
      endcase
    end
  end

  // Allocator only grants an input whose head was decoded as valid
  a_pop_valid: assert property (@(posedge clk) disable iff (!reset_n)
    i_pop |-> o_head_val);

  // Pointers meet only on an empty or a full buffer
  a_ptr_count: assert property (@(posedge clk) disable iff (!reset_n)
    (wr_ptr == rd_ptr) == ((count == '0) || (count == cnt_t'(QUEUE_DEPTH))));

endmodule

/* hw/route_decoder.sv */
// ------------------------------------------------------------------------
// XY route decoder
// Turns the destination of a queue head into a one-hot output request,
// x dimension first, then y
// ------------------------------------------------------------------------

module route_decoder #(
  parameter noc_pkg::coord_t X_LOC = '0,       // This router's column
  parameter noc_pkg::coord_t Y_LOC = '0        // This router's row
) (
  input  noc_pkg::packet_t    i_head,          // Head packet of the queue
  input  logic                i_head_val,      // Head is valid
  output noc_pkg::port_mask_t o_req            // One-hot requested output
);
  import noc_pkg::*;

  coord_t dest_x;
  coord_t dest_y;

  // Destination fields sit above the payload
  assign dest_x = i_head[PACKET_W-1 -: COORD_W];
  assign dest_y = i_head[PACKET_W-COORD_W-1 -: COORD_W];

  always_comb begin
    o_req = '0;                                  // No request without a head
    if (i_head_val) begin
      if (dest_x > X_LOC) begin
        o_req[PORT_EAST] = 1'b1;
      end else if (dest_x < X_LOC) begin
        o_req[PORT_WEST] = 1'b1;
      end else if (dest_y > Y_LOC) begin         // Column reached, now y
        o_req[PORT_SOUTH] = 1'b1;
      end else if (dest_y < Y_LOC) begin
        o_req[PORT_NORTH] = 1'b1;
      end else begin
        o_req[PORT_CORE] = 1'b1;                 // Arrived
      end
    end
  end

endmodule

/* hw/switch_allocator.sv */
// ------------------------------------------------------------------------
// Switch allocator
// Per-output round-robin arbitration of input requests, gated by the
// downstream enables; drives the crossbar grants and the queue pops
// ------------------------------------------------------------------------

module switch_allocator (
  input  logic                                         clk,
  input  logic                                         reset_n,
  input  noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0] i_req,       // Per input
  input  noc_pkg::port_mask_t                          i_en,        // From downstream
  output noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0] o_out_grant, // Per output
  output noc_pkg::port_mask_t                          o_in_grant   // Pops, per input
);
  import noc_pkg::*;

  localparam int unsigned IDX_W = $clog2(NUM_PORTS);

  typedef logic [IDX_W-1:0] idx_t;                   // Port number

  port_mask_t [NUM_PORTS-1:0] req_t;                 // Requests per output
  idx_t       [NUM_PORTS-1:0] ptr;                   // Round-robin start per output
  idx_t       [NUM_PORTS-1:0] ptr_nxt;

  // Port number step places on, modulo NUM_PORTS
  function automatic idx_t wrap_add(idx_t base, int unsigned step);
    int unsigned sum;
    sum = base + step;
    if (sum >= NUM_PORTS) begin
      sum = sum - NUM_PORTS;
    end
    return idx_t'(sum);
  endfunction

  // Transpose, input-major requests become output-major
  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        req_t[o][i] = i_req[i][o];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------------------
  // Scan from the farthest slot back so the slot nearest the pointer wins
  always_comb begin
    o_out_grant = '0;
    ptr_nxt     = ptr;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int k = NUM_PORTS - 1; k >= 0; k--) begin
        if (i_en[o] && req_t[o][wrap_add(ptr[o], k)]) begin
          o_out_grant[o]                         = '0;
          o_out_grant[o][wrap_add(ptr[o], k)]    = 1'b1;
          ptr_nxt[o]                             = wrap_add(ptr[o], k + 1);  // Just past winner
        end
      end
    end
  end

  // An input requests one output only, so at most one bit per column
  always_comb begin
    o_in_grant = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      o_in_grant = o_in_grant | o_out_grant[o];
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        ptr[o] <= idx_t'(PORT_CORE);
      end
    end else begin
      ptr <= ptr_nxt;
    end
  end

  // Checks per input
  // The OR into o_in_grant needs a single requested output per input
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_chk
    a_req_onehot: assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(i_req[i]));
  end

endmodule

/* hw/output_stage.sv */
// ------------------------------------------------------------------------
// Output stage
// One-hot crossbar from the queue heads to the outputs, followed by the
// output data and valid registers
// ------------------------------------------------------------------------

module output_stage (
  input  logic                                         clk,
  input  logic                                         reset_n,
  input  noc_pkg::packet_t    [noc_pkg::NUM_PORTS-1:0] i_heads,     // Per input
  input  noc_pkg::port_mask_t [noc_pkg::NUM_PORTS-1:0] i_out_grant, // Per output
  output noc_pkg::packet_t    [noc_pkg::NUM_PORTS-1:0] o_data,      // Per output
  output noc_pkg::port_mask_t                          o_data_val   // Per output
);
  import noc_pkg::*;

  packet_t    [NUM_PORTS-1:0] xbar_data;                // Crossbar result
  port_mask_t                 xbar_val;

  // AND-OR mux, a one-hot grant picks a single head
  always_comb begin
    xbar_data = '0;
    xbar_val  = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (i_out_grant[o][i]) begin
          xbar_data[o] = xbar_data[o] | i_heads[i];
        end
      end
      xbar_val[o] = |i_out_grant[o];                     // Any grant means valid
    end
  end

  // Data register, qualified by o_data_val
  always_ff @(posedge clk) begin
    o_data <= xbar_data;
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      o_data_val <= '0;
    end else begin
      o_data_val <= xbar_val;                            // One pulse per grant
    end
  end

endmodule

/* hw/mesh_router.sv */
// ------------------------------------------------------------------------
// Mesh router
// Five-port input-buffered router for a 2D mesh with XY routing and
// valid/enable flow control on both sides
// ------------------------------------------------------------------------

module mesh_router #(
  parameter noc_pkg::coord_t X_LOC       = '0,   // Column of this node
  parameter noc_pkg::coord_t Y_LOC       = '0,   // Row of this node
  parameter int unsigned     QUEUE_DEPTH = 4     // Packets per input queue
) (
  input  logic                                      clk,
  input  logic                                      reset_n,

  // Upstream side
  input  noc_pkg::packet_t [noc_pkg::NUM_PORTS-1:0] i_data,      // From neighbors
  input  noc_pkg::port_mask_t                       i_data_val,
  output noc_pkg::port_mask_t                       o_en,        // Queue not full

  // Downstream side
  output noc_pkg::packet_t [noc_pkg::NUM_PORTS-1:0] o_data,      // To neighbors
  output noc_pkg::port_mask_t                       o_data_val,
  input  noc_pkg::port_mask_t                       i_en         // Neighbor can take one
);
  import noc_pkg::*;

  packet_t    [NUM_PORTS-1:0] head;              // Queue heads
  port_mask_t                 head_val;
  port_mask_t [NUM_PORTS-1:0] req;               // Decoded request per input
  port_mask_t [NUM_PORTS-1:0] out_grant;         // Crossbar select per output
  port_mask_t                 in_grant;          // Queue pops

  // ------------------------------------------------------------------------
  // Input ports, queue plus route decode on its head
  // ------------------------------------------------------------------------
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    input_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) input_queue_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[p]),
      .i_data_val (i_data_val[p]),
      .i_pop      (in_grant[p]),
      .o_head     (head[p]),
      .o_head_val (head_val[p]),
      .o_en       (o_en[p])
    );

    route_decoder #(.X_LOC(X_LOC), .Y_LOC(Y_LOC)) route_decoder_i (
      .i_head     (head[p]),
      .i_head_val (head_val[p]),
      .o_req      (req[p])
    );
  end

  // Arbitration against downstream enables
  switch_allocator switch_allocator_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_req       (req),
    .i_en        (i_en),
    .o_out_grant (out_grant),
    .o_in_grant  (in_grant)
  );

  // Crossbar and output registers
  output_stage output_stage_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .i_heads     (head),
    .i_out_grant (out_grant),
    .o_data      (o_data),
    .o_data_val  (o_data_val)
  );

endmodule

/* bench/router_tb.sv */
// --------------------------------------------------------------------------
// Mesh router testbench
// Replays the stimulus file phase by phase and checks each output packet
// against per-source expectations, flow control and round-robin order
// --------------------------------------------------------------------------

module router_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import noc_pkg::*;

  localparam int MAX_PKTS = 64;
  localparam int MAX_PH   = 16;
  localparam int DEPTH    = 4;                  // Queue depth of the DUT

  logic                       clk;
  logic                       reset_n;
  packet_t    [NUM_PORTS-1:0] i_data;
  port_mask_t                 i_data_val;
  port_mask_t                 o_en;
  packet_t    [NUM_PORTS-1:0] o_data;
  port_mask_t                 o_data_val;
  port_mask_t                 i_en;

  // Stimulus tables, filled once from the file
  packet_t    pkt_data [MAX_PKTS];
  int         pkt_src  [MAX_PKTS];
  int         pkt_out  [MAX_PKTS];
  bit         pkt_done [MAX_PKTS];             // Seen on its output
  port_mask_t ph_mask  [MAX_PH];
  int         ph_cycles[MAX_PH];
  int         ph_mode  [MAX_PH];
  int         ph_first [MAX_PH+1];             // First packet of each phase
  int         n_pkts, n_ph, n_lines, n_done, released, cycles, limit;

  // Per-input driver and scoreboard state
  int         cur      [NUM_PORTS];            // Packet on offer, -1 when idle
  int         next_idx [NUM_PORTS];
  int         gap      [NUM_PORTS];            // Idle cycles before next offer
  int         accepted [NUM_PORTS];
  int         delivered[NUM_PORTS];
  port_mask_t offer_ok;                        // Valid and o_en at the coming edge
  port_mask_t en_mask;
  bit         gaps_on;
  bit         watch_on;                        // Core output alternation check
  int         last_core_src;

  mesh_router #(.X_LOC(3'd2), .Y_LOC(3'd2), .QUEUE_DEPTH(DEPTH)) mesh_router_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;                    // 40 ns period
  end

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic load_stimulus();
    int       fd, src, x, y, out, cyc, mode;
    payload_t pay;
    port_mask_t mask;
    string    line;
    fd = $fopen("bench/router_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file bench/router_stimulus.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;   // Blank or comment
      if ($sscanf(line, "P %h %d %d", mask, cyc, mode) == 3) begin
        ph_first[n_ph]  = n_pkts;
        ph_mask[n_ph]   = mask;
        ph_cycles[n_ph] = cyc;
        ph_mode[n_ph]   = mode;
        n_ph++;
      end else if ($sscanf(line, "K %d %d %d %h %d", src, x, y, pay, out) == 5) begin
        pkt_data[n_pkts] = {coord_t'(x), coord_t'(y), pay};
        pkt_src[n_pkts]  = src;
        pkt_out[n_pkts]  = out;
        n_pkts++;
      end else begin
        $display("Stimulus line could not be parsed: %s", line);
        abort_run();
      end
      n_lines++;
    end
    ph_first[n_ph] = n_pkts;
    $fclose(fd);
  endtask

  // Oldest undelivered packet from input s to output o
  function automatic int oldest_pending(int s, int o);
    for (int k = 0; k < released; k++) begin
      if (!pkt_done[k] && pkt_src[k] == s && pkt_out[k] == o) return k;
    end
    return -1;
  endfunction

  task automatic check_outputs(port_mask_t en_last);
    int hit;
    int h;
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (o_data_val[o]) begin
        assert (en_last[o]) else begin
          $display("[FAIL] %0d ns: output %0d pulsed after a low enable", $time, o);
          abort_run();
        end
        hit = -1;
        for (int s = 0; s < NUM_PORTS; s++) begin
          h = oldest_pending(s, o);
          if (h >= 0 && pkt_data[h] == o_data[o]) hit = h;
        end
        assert (hit >= 0) else begin
          $display("[FAIL] %0d ns: output %0d sent unexpected packet %h", $time, o, o_data[o]);
          abort_run();
        end
        pkt_done[hit] = 1'b1;
        n_done++;
        delivered[pkt_src[hit]]++;
        if (watch_on && o == PORT_CORE) begin
          assert (pkt_src[hit] != last_core_src) else begin
            $display("[FAIL] %0d ns: core output served input %0d twice in a row",
                     $time, pkt_src[hit]);
            abort_run();
          end
          last_core_src = pkt_src[hit];
        end
      end
    end
  endtask

  task automatic drive_inputs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (offer_ok[p]) begin                   // Taken at the edge just passed
        accepted[p]++;
        cur[p] = -1;
        gap[p] = gaps_on ? int'($urandom % 2) : 0;
      end
      // Queue holds accepted minus delivered, o_en high while not full
      assert (o_en[p] == ((accepted[p] - delivered[p]) < DEPTH)) else begin
        $display("[FAIL] %0d ns: o_en[%0d] wrong with %0d packets queued",
                 $time, p, accepted[p] - delivered[p]);
        abort_run();
      end
      if (cur[p] < 0) begin
        while (next_idx[p] < released && pkt_src[next_idx[p]] != p) next_idx[p]++;
        if (next_idx[p] < released) begin
          if (gap[p] > 0) begin
            gap[p]--;
          end else begin
            cur[p] = next_idx[p];
            next_idx[p]++;
          end
        end
      end
      i_data_val[p] = (cur[p] >= 0);           // Held until accepted
      i_data[p]     = (cur[p] >= 0) ? pkt_data[cur[p]] : '0;
      offer_ok[p]   = i_data_val[p] && o_en[p];
    end
    i_en = en_mask;
  endtask

  // One clock cycle, everything on the falling edge
  task automatic step();
    port_mask_t en_last;
    @(negedge clk);
    cycles++;
    assert (cycles <= limit) else begin
      $display("Timeout, packets still missing after %0d cycles", limit);
      abort_run();
    end
    en_last = i_en;
    check_outputs(en_last);
    drive_inputs();
  endtask

  initial begin
    void'($urandom(47122));
    reset_n    = 1'b0;
    i_data     = '0;
    i_data_val = '0;
    i_en       = '0;
    en_mask    = '0;
    offer_ok   = '0;
    cur        = '{default: -1};
    next_idx   = '{default: 0};
    gap        = '{default: 0};
    accepted   = '{default: 0};
    delivered  = '{default: 0};
    load_stimulus();
    limit = 20 * n_lines + 200;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    for (int ph = 0; ph < n_ph; ph++) begin
      en_mask       = ph_mask[ph];
      gaps_on       = (ph_mode[ph] == 0);
      watch_on      = (ph_mode[ph] == 1);
      last_core_src = -1;
      released      = ph_first[ph+1];          // Packets of this phase go live
      if (!gaps_on) gap = '{default: 0};
      repeat (ph_cycles[ph]) step();
    end
    en_mask  = '1;                             // Drain with all outputs open
    watch_on = 1'b0;
    while (n_done < n_pkts) step();
    repeat (4) step();                         // Any pulse here is a duplicate
    $display("** PASS **");
    $finish;
  end

endmodule

/* bench/router_stimulus.txt */
# P <enable mask hex> <cycles> <mode 0 random gaps, 1 no gaps and core alternation check>
# K <input> <dest x> <dest y> <payload hex> <expected output>, ports 0 core 1 N 2 E 3 S 4 W
P 1f 16 0
K 0 5 2 1001 2
K 0 0 2 1002 4
K 0 2 6 1003 3
K 0 2 0 1004 1
K 0 2 2 1005 0
K 1 2 2 1101 0
K 2 2 2 1201 0
K 3 2 2 1301 0
K 4 2 2 1401 0
K 1 3 0 1102 2
K 3 1 7 1302 4
P 1b 10 0
K 0 4 4 2001 2
K 2 6 1 2201 2
P 00 12 0
K 4 3 2 4401 2
K 4 2 5 4402 3
K 4 2 0 4403 1
K 4 0 0 4404 4
K 4 7 2 4405 2
K 4 2 7 4406 3
P 1f 20 1
K 1 2 2 5101 0
K 3 2 2 5301 0
K 1 2 2 5102 0
K 3 2 2 5302 0
K 1 2 2 5103 0
K 3 2 2 5303 0

/* list.f */
hw/noc_pkg.sv
hw/input_queue.sv
hw/route_decoder.sv
hw/switch_allocator.sv
hw/output_stage.sv
hw/mesh_router.sv
bench/router_tb.sv

/* Bender.yml */
package:
  name: mesh_router

sources:
  - files:
      - hw/noc_pkg.sv
      - hw/input_queue.sv
      - hw/route_decoder.sv
      - hw/switch_allocator.sv
      - hw/output_stage.sv
      - hw/mesh_router.sv
  - target: test
    files:
      - bench/router_tb.sv
